// File: hdl/apb_slot_decoder.sv
// APB slot decoder
// Picks a 4 kB slot from the address, forwards the request with its
// select gated and the address cut to the in-slot offset, and muxes
// the response back. Empty slots answer with an error.

`timescale 1ns/1ps

`include "periph_defines.svh"

module apb_slot_decoder (
    input  periph_pkg::apb_req_t bus_req,
    output periph_pkg::apb_rsp_t bus_rsp,

    output periph_pkg::apb_req_t timer_req,
    input  periph_pkg::apb_rsp_t timer_rsp,

    output periph_pkg::apb_req_t padctrl_req,
    input  periph_pkg::apb_rsp_t padctrl_rsp
);

    localparam int SLOT_W = $clog2(`PERIPH_N_SLOTS);

    logic [SLOT_W-1:0] slot;

    assign slot = bus_req.paddr[`PERIPH_SLOT_LSB +: SLOT_W];

    // ------------------------------------------------------------
    // Request side

    function automatic periph_pkg::apb_req_t slot_req(
        input periph_pkg::apb_req_t req,
        input logic                 hit
    );
        periph_pkg::apb_req_t r;
        r = req;
        r.psel = req.psel & hit;
        // Keep only the offset within the slot
        r.paddr = {{(`PERIPH_W_ADDR - `PERIPH_SLOT_LSB){1'b0}},
                   req.paddr[`PERIPH_SLOT_LSB-1:0]};
        return r;
    endfunction

    assign timer_req   = slot_req(bus_req, slot == SLOT_W'(`PERIPH_SLOT_TIMER));
    assign padctrl_req = slot_req(bus_req, slot == SLOT_W'(`PERIPH_SLOT_PADCTRL));

    // ------------------------------------------------------------
    // Response side

    always_comb begin
        case (slot)
            SLOT_W'(`PERIPH_SLOT_TIMER):   bus_rsp = timer_rsp;
            SLOT_W'(`PERIPH_SLOT_PADCTRL): bus_rsp = padctrl_rsp;
            default: begin
                // Nothing lives here, finish at once with an error
                bus_rsp.prdata  = '0;
                bus_rsp.pready  = 1'b1;
                bus_rsp.pslverr = 1'b1;
            end
        endcase
    end

endmodule

// File: hdl/padctrl.sv
// Pad control register file
// One slew/drive/Schmitt register per pad group plus the GPIO pull
// register, all driven straight onto the pad control outputs

`timescale 1ns/1ps

`include "periph_defines.svh"

module padctrl (
    input  logic                                                clk,
    input  logic                                                rst_n,

    input  periph_pkg::apb_req_t                                apb_req,
    output periph_pkg::apb_rsp_t                                apb_rsp,

    output periph_pkg::pad_ctrl_t [periph_pkg::PAD_N_GROUPS-1:0] pad_ctrl,
    output logic [`PERIPH_N_GPIO-1:0]                           gpio_pu,
    output logic [`PERIPH_N_GPIO-1:0]                           gpio_pd
);

    localparam periph_pkg::pad_ctrl_t PAD_RESET = '{
        schmitt: 1'b0,
        slew:    1'b0,
        drive:   `PAD_DRIVE_RESET
    };

    logic [`PERIPH_SLOT_LSB-1:0] reg_addr;
    periph_pkg::pad_group_e      grp;
    logic                        grp_hit;
    logic                        pull_hit;
    logic                        wr_en;
    periph_pkg::padctrl_word_u   wword;
    periph_pkg::padctrl_word_u   rword;

    // Output-only groups have no Schmitt trigger
    function automatic periph_pkg::pad_ctrl_t mask_schmitt(
        input periph_pkg::pad_ctrl_t  c,
        input periph_pkg::pad_group_e g
    );
        periph_pkg::pad_ctrl_t r;
        r = c;
        r.schmitt = c.schmitt & periph_pkg::PAD_HAS_SCHMITT[g];
        return r;
    endfunction

    // ------------------------------------------------------------
    // Address decode

    assign reg_addr = {apb_req.paddr[`PERIPH_SLOT_LSB-1:2], 2'b00};
    assign grp      = periph_pkg::pad_group_e'(reg_addr[5:2]);
    assign grp_hit  = (reg_addr[`PERIPH_SLOT_LSB-1:6] == '0) && (grp <= periph_pkg::GPIO);
    assign pull_hit = reg_addr == `PADCTRL_REG_GPIO_PULL;

    assign wr_en = apb_req.psel && apb_req.penable && apb_req.pwrite;
    assign wword = apb_req.pwdata;

    // ------------------------------------------------------------
    // Registers

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int g = 0; g < periph_pkg::PAD_N_GROUPS; g++) begin
                pad_ctrl[g] <= PAD_RESET;
            end
            gpio_pu <= '0;
            gpio_pd <= '0;
        end else if (wr_en) begin
            if (grp_hit) begin
                pad_ctrl[grp] <= mask_schmitt(wword.group.ctrl, grp);
            end
            if (pull_hit) begin
                gpio_pu <= wword.pull.pu;
                gpio_pd <= wword.pull.pd;
            end
        end
    end

    // ------------------------------------------------------------
    // Readback, unused offsets read as zero

    always_comb begin
        rword = '0;
        if (grp_hit) begin
            rword.group.ctrl = mask_schmitt(pad_ctrl[grp], grp);
        end else if (pull_hit) begin
            rword.pull.pu = gpio_pu;
            rword.pull.pd = gpio_pd;
        end
    end

    assign apb_rsp.prdata  = rword;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = 1'b0;

endmodule

// File: hdl/periph_defines.svh
// APB peripheral subsystem constants
// Bus widths, slot map, register offsets and reset values

`ifndef PERIPH_DEFINES_SVH
`define PERIPH_DEFINES_SVH

// ------------------------------------------------------------
// Bus widths
`define PERIPH_W_ADDR          16
`define PERIPH_W_DATA          32
`define PERIPH_N_GPIO          7

// ------------------------------------------------------------
// Slot map, 4 kB window per slot
`define PERIPH_N_SLOTS         4
`define PERIPH_SLOT_LSB        12
`define PERIPH_SLOT_TIMER      0
`define PERIPH_SLOT_PADCTRL    1

// ------------------------------------------------------------
// Timer register byte offsets
`define TIMER_REG_CTRL         12'h000
`define TIMER_REG_MTIME        12'h008
`define TIMER_REG_MTIMEH       12'h00c
`define TIMER_REG_MTIMECMP     12'h010
`define TIMER_REG_MTIMECMPH    12'h014

// ------------------------------------------------------------
// Pad control, group registers live at 4 * group index
`define PADCTRL_REG_GPIO_PULL  12'h028

// Mid drive strength out of reset
`define PAD_DRIVE_RESET        2'b01

`endif

// File: hdl/periph_pkg.sv
// Shared types for the APB peripheral subsystem
// Bus request/response, pad control fields and register word views

`include "periph_defines.svh"

package periph_pkg;

    // APB request, master to slave
    typedef struct packed {
        logic                      psel;
        logic                      penable;
        logic                      pwrite;
        logic [`PERIPH_W_ADDR-1:0] paddr;
        logic [`PERIPH_W_DATA-1:0] pwdata;
    } apb_req_t;

    // APB response, slave to master
    typedef struct packed {
        logic [`PERIPH_W_DATA-1:0] prdata;
        logic                      pready;
        logic                      pslverr;
    } apb_rsp_t;

    // Per-group pad settings
    typedef struct packed {
        logic       schmitt;
        logic       slew;
        logic [1:0] drive;
    } pad_ctrl_t;

    typedef enum logic [3:0] {
        DIO         = 4'd0,
        SRAM_DQ     = 4'd1,
        SRAM_A      = 4'd2,
        SRAM_STROBE = 4'd3,
        AUDIO       = 4'd4,
        LCD_CLK     = 4'd5,
        LCD_DAT     = 4'd6,
        LCD_DCCS    = 4'd7,
        LCD_BL      = 4'd8,
        GPIO        = 4'd9
    } pad_group_e;

    localparam int PAD_N_GROUPS = int'(GPIO) + 1;

    // Groups with input buffers: DIO, SRAM_DQ, GPIO
    localparam logic [PAD_N_GROUPS-1:0] PAD_HAS_SCHMITT = 10'b10_0000_0011;

    // GPIO pulls, pu in 6:0 and pd in 22:16
    typedef struct packed {
        logic [15-`PERIPH_N_GPIO:0] rsvd_hi;
        logic [`PERIPH_N_GPIO-1:0]  pd;
        logic [15-`PERIPH_N_GPIO:0] rsvd_lo;
        logic [`PERIPH_N_GPIO-1:0]  pu;
    } gpio_pull_t;

    typedef struct packed {
        logic [`PERIPH_W_DATA-5:0] rsvd;
        pad_ctrl_t                 ctrl;
    } pad_word_t;

    // One register word, decoded by offset
    typedef union packed {
        pad_word_t  group;
        gpio_pull_t pull;
    } padctrl_word_u;

endpackage

// File: hdl/periph_subsys.sv
// APB peripheral subsystem top level
// Slot decoder in front of the machine timer and the pad control block

`timescale 1ns/1ps

`include "periph_defines.svh"

module periph_subsys (
    input  logic                                                clk,
    input  logic                                                rst_n,

    input  periph_pkg::apb_req_t                                bus_req,
    output periph_pkg::apb_rsp_t                                bus_rsp,

    input  logic                                                dbg_halt,
    output logic                                                timer_irq,

    output periph_pkg::pad_ctrl_t [periph_pkg::PAD_N_GROUPS-1:0] pad_ctrl,
    output logic [`PERIPH_N_GPIO-1:0]                           gpio_pu,
    output logic [`PERIPH_N_GPIO-1:0]                           gpio_pd
);

    periph_pkg::apb_req_t timer_req;
    periph_pkg::apb_rsp_t timer_rsp;
    periph_pkg::apb_req_t padctrl_req;
    periph_pkg::apb_rsp_t padctrl_rsp;

    // ------------------------------------------------------------
    // Slot 0 timer, slot 1 pad control, slots 2 and 3 empty

    apb_slot_decoder decoder_u (
        .bus_req     (bus_req),
        .bus_rsp     (bus_rsp),
        .timer_req   (timer_req),
        .timer_rsp   (timer_rsp),
        .padctrl_req (padctrl_req),
        .padctrl_rsp (padctrl_rsp)
    );

    riscv_timer timer_u (
        .clk       (clk),
        .rst_n     (rst_n),
        .apb_req   (timer_req),
        .apb_rsp   (timer_rsp),
        .dbg_halt  (dbg_halt),
        .timer_irq (timer_irq)
    );

    padctrl padctrl_u (
        .clk      (clk),
        .rst_n    (rst_n),
        .apb_req  (padctrl_req),
        .apb_rsp  (padctrl_rsp),
        .pad_ctrl (pad_ctrl),
        .gpio_pu  (gpio_pu),
        .gpio_pd  (gpio_pd)
    );

endmodule

// File: hdl/riscv_timer.sv
// RISC-V machine timer
// 64-bit mtime counter and mtimecmp compare behind APB, accessed as
// 32-bit halves, with a registered timer interrupt

`timescale 1ns/1ps

`include "periph_defines.svh"

module riscv_timer (
    input  logic                 clk,
    input  logic                 rst_n,

    input  periph_pkg::apb_req_t apb_req,
    output periph_pkg::apb_rsp_t apb_rsp,

    input  logic                 dbg_halt,
    output logic                 timer_irq
);

    logic [`PERIPH_SLOT_LSB-1:0] reg_addr;
    logic                        wr_en;
    logic [`PERIPH_W_DATA-1:0]   wdata;

    logic                        ctrl_en;
    logic [63:0]                 mtime;
    logic [63:0]                 mtimecmp;
    logic                        count_en;

    assign reg_addr = {apb_req.paddr[`PERIPH_SLOT_LSB-1:2], 2'b00};
    assign wr_en    = apb_req.psel && apb_req.penable && apb_req.pwrite;
    assign wdata    = apb_req.pwdata;

    // Frozen while the core is halted in debug
    assign count_en = ctrl_en && !dbg_halt;

    // ------------------------------------------------------------
    // Control and compare registers

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl_en  <= 1'b0;
            mtimecmp <= '1;
        end else if (wr_en) begin
            case (reg_addr)
                `TIMER_REG_CTRL:      ctrl_en         <= wdata[0];
                `TIMER_REG_MTIMECMP:  mtimecmp[31:0]  <= wdata;
                `TIMER_REG_MTIMECMPH: mtimecmp[63:32] <= wdata;
                default: ;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Counter, a bus write wins over the increment

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtime <= '0;
        end else if (wr_en && reg_addr == `TIMER_REG_MTIME) begin
            mtime[31:0] <= wdata;
        end else if (wr_en && reg_addr == `TIMER_REG_MTIMEH) begin
            mtime[63:32] <= wdata;
        end else if (count_en) begin
            mtime <= mtime + 64'd1;
        end
    end

    // ------------------------------------------------------------
    // Interrupt, one cycle behind the compare

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            timer_irq <= 1'b0;
        end else begin
            timer_irq <= mtime >= mtimecmp;
        end
    end

    // ------------------------------------------------------------
    // Readback

    always_comb begin
        case (reg_addr)
            `TIMER_REG_CTRL:      apb_rsp.prdata = {{(`PERIPH_W_DATA-1){1'b0}}, ctrl_en};
            `TIMER_REG_MTIME:     apb_rsp.prdata = mtime[31:0];
            `TIMER_REG_MTIMEH:    apb_rsp.prdata = mtime[63:32];
            `TIMER_REG_MTIMECMP:  apb_rsp.prdata = mtimecmp[31:0];
            `TIMER_REG_MTIMECMPH: apb_rsp.prdata = mtimecmp[63:32];
            default:              apb_rsp.prdata = '0;
        endcase
    end

    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = 1'b0;

endmodule

// File: riscboy_periph.f
+incdir+hdl
hdl/periph_pkg.sv
hdl/apb_slot_decoder.sv
hdl/padctrl.sv
hdl/riscv_timer.sv
hdl/periph_subsys.sv
testbench/periph_tb.sv

// File: testbench/periph_tb.sv
// Directed testbench for the APB peripheral subsystem
// Runs APB transfers into the top level and checks pad control,
// GPIO pulls, slot decode, timer counting and the timer interrupt

`timescale 1ns/1ps

`include "periph_defines.svh"

module periph_tb;

    localparam logic [15:0] TIMER_BASE = 16'h0000;
    localparam logic [15:0] PAD_BASE   = 16'h1000;
    localparam int          XFER_LIMIT = 20;

    logic                                                 clk;
    logic                                                 rst_n;
    logic                                                 dbg_halt;
    logic                                                 timer_irq;
    periph_pkg::apb_req_t                                 bus_req;
    periph_pkg::apb_rsp_t                                 bus_rsp;
    periph_pkg::pad_ctrl_t [periph_pkg::PAD_N_GROUPS-1:0] pad_ctrl;
    logic [`PERIPH_N_GPIO-1:0]                            gpio_pu;
    logic [`PERIPH_N_GPIO-1:0]                            gpio_pd;

    int          errors;
    logic [31:0] rng;

    // Expected pad state as built up by the writes so far
    periph_pkg::pad_ctrl_t [periph_pkg::PAD_N_GROUPS-1:0] pad_model;
    logic [31:0]                                          pull_model;

    periph_subsys uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp),
        .dbg_halt  (dbg_halt),
        .timer_irq (timer_irq),
        .pad_ctrl  (pad_ctrl),
        .gpio_pu   (gpio_pu),
        .gpio_pd   (gpio_pd)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Watchdog for the whole run
    initial begin
        #200_000;
        $display("Simulation ran past its time limit");
        $display("*** FAILED ***");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Only DIO, SRAM_DQ and GPIO keep the Schmitt bit
    function automatic periph_pkg::pad_ctrl_t pad_expect(input int g, input logic [31:0] w);
        periph_pkg::pad_ctrl_t e;
        e.schmitt = w[3] && (g == 0 || g == 1 || g == 9);
        e.slew    = w[2];
        e.drive   = w[1:0];
        return e;
    endfunction

    // ------------------------------------------------------------
    // Compare tasks

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_pad(input string name, input periph_pkg::pad_ctrl_t got,
                             input periph_pkg::pad_ctrl_t exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    // ------------------------------------------------------------
    // APB driver that returns at the falling edge after the access edge

    task automatic apb_transfer(input logic wr, input logic [15:0] addr, input logic [31:0] wdata,
                                output logic [31:0] rdata, output logic err);
        int n;
        n = 0;
        @(posedge clk);
        bus_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk);
        bus_req.penable <= 1'b1;
        @(negedge clk);
        while (!bus_rsp.pready && n < XFER_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!bus_rsp.pready) begin
            errors++;
            $display("Transfer to address %h never saw pready", addr);
        end
        rdata = bus_rsp.prdata;
        err   = bus_rsp.pslverr;
        @(posedge clk);
        bus_req <= '0;
        @(negedge clk);
    endtask

    task automatic apb_write(input logic [15:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        apb_transfer(1'b1, addr, data, rd, err);
    endtask

    task automatic apb_read(input logic [15:0] addr, output logic [31:0] data, output logic err);
        apb_transfer(1'b0, addr, 32'h0, data, err);
    endtask

    task automatic wait_irq(input logic level, input int limit);
        int n;
        n = 0;
        while (timer_irq !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (timer_irq !== level) begin
            errors++;
            $display("timer_irq did not reach %b within %0d cycles", level, limit);
        end
    endtask

    // ------------------------------------------------------------
    // Directed tests

    task automatic test_reset;
        logic [31:0] rd;
        logic        err;
        periph_pkg::pad_ctrl_t exp;
        exp = '{schmitt: 1'b0, slew: 1'b0, drive: `PAD_DRIVE_RESET};
        for (int g = 0; g < periph_pkg::PAD_N_GROUPS; g++) begin
            check_pad($sformatf("pad_ctrl[%0d] reset", g), pad_ctrl[g], exp);
        end
        check_word("gpio_pu reset", 32'(gpio_pu), 32'h0);
        check_word("gpio_pd reset", 32'(gpio_pd), 32'h0);
        check_bit("timer_irq reset", timer_irq, 1'b0);
        apb_read(TIMER_BASE | `TIMER_REG_MTIMECMP, rd, err);
        check_word("mtimecmp reset", rd, 32'hffff_ffff);
        apb_read(TIMER_BASE | `TIMER_REG_MTIMECMPH, rd, err);
        check_word("mtimecmph reset", rd, 32'hffff_ffff);
    endtask

    task automatic test_pad_groups;
        logic [31:0] rd;
        logic        err;
        periph_pkg::pad_ctrl_t exp;
        for (int g = 0; g < periph_pkg::PAD_N_GROUPS; g++) begin
            rng = xorshift32(rng);
            apb_write(PAD_BASE + 16'(4 * g), rng);
            exp = pad_expect(g, rng);
            pad_model[g] = exp;
            check_pad($sformatf("pad_ctrl[%0d]", g), pad_ctrl[g], exp);
            apb_read(PAD_BASE + 16'(4 * g), rd, err);
            check_word($sformatf("group %0d readback", g), rd, {28'h0, exp});
        end
    endtask

    task automatic test_gpio_pulls;
        logic [31:0] rd;
        logic [31:0] w;
        logic        err;
        rng = xorshift32(rng);
        w = rng;
        pull_model = w;
        apb_write(PAD_BASE | `PADCTRL_REG_GPIO_PULL, w);
        check_word("gpio_pu", 32'(gpio_pu), 32'(w[6:0]));
        check_word("gpio_pd", 32'(gpio_pd), 32'(w[22:16]));
        apb_read(PAD_BASE | `PADCTRL_REG_GPIO_PULL, rd, err);
        check_word("pull readback", rd, w & 32'h007f_007f);
        // A group write must not disturb the pulls
        apb_write(PAD_BASE + 16'h0004, ~w);
        pad_model[1] = pad_expect(1, ~w);
        check_word("gpio_pu after group write", 32'(gpio_pu), 32'(w[6:0]));
        check_word("gpio_pd after group write", 32'(gpio_pd), 32'(w[22:16]));
    endtask

    task automatic test_slot_decode;
        logic [31:0] rd;
        logic        err;
        apb_read(16'h2000, rd, err);
        check_bit("slot 2 pslverr", err, 1'b1);
        check_word("slot 2 prdata", rd, 32'h0);
        apb_read(16'h3004, rd, err);
        check_bit("slot 3 pslverr", err, 1'b1);
        check_word("slot 3 prdata", rd, 32'h0);
        apb_write(16'h2000, 32'h0000_000f);
        apb_write(16'h3004, 32'h0000_000e);
        for (int g = 0; g < periph_pkg::PAD_N_GROUPS; g++) begin
            check_pad($sformatf("pad_ctrl[%0d] after empty slot write", g),
                      pad_ctrl[g], pad_model[g]);
        end
        check_word("gpio_pu after empty slot write", 32'(gpio_pu), 32'(pull_model[6:0]));
        check_word("gpio_pd after empty slot write", 32'(gpio_pd), 32'(pull_model[22:16]));
        apb_read(PAD_BASE + 16'h0030, rd, err);
        check_bit("unused offset pslverr", err, 1'b0);
        check_word("unused offset prdata", rd, 32'h0);
    endtask

    task automatic test_timer_count;
        logic [31:0] t1;
        logic [31:0] t2;
        logic        err;
        apb_write(TIMER_BASE | `TIMER_REG_CTRL, 32'h1);
        apb_read(TIMER_BASE | `TIMER_REG_MTIME, t1, err);
        apb_read(TIMER_BASE | `TIMER_REG_MTIME, t2, err);
        check_bit("mtime advances", t2 > t1, 1'b1);
        @(posedge clk);
        dbg_halt <= 1'b1;
        apb_read(TIMER_BASE | `TIMER_REG_MTIME, t1, err);
        apb_read(TIMER_BASE | `TIMER_REG_MTIME, t2, err);
        check_word("mtime frozen in halt", t2, t1);
        @(posedge clk);
        dbg_halt <= 1'b0;
        apb_write(TIMER_BASE | `TIMER_REG_CTRL, 32'h0);
        rng = xorshift32(rng);
        apb_write(TIMER_BASE | `TIMER_REG_MTIME, rng);
        apb_read(TIMER_BASE | `TIMER_REG_MTIME, t1, err);
        check_word("mtime write readback", t1, rng);
    endtask

    task automatic test_timer_irq;
        apb_write(TIMER_BASE | `TIMER_REG_MTIMEH, 32'h0);
        apb_write(TIMER_BASE | `TIMER_REG_MTIME, 32'h0);
        apb_write(TIMER_BASE | `TIMER_REG_MTIMECMP, 32'd40);
        apb_write(TIMER_BASE | `TIMER_REG_MTIMECMPH, 32'h0);
        check_bit("timer_irq before enable", timer_irq, 1'b0);
        apb_write(TIMER_BASE | `TIMER_REG_CTRL, 32'h1);
        wait_irq(1'b1, 200);
        apb_write(TIMER_BASE | `TIMER_REG_MTIMECMPH, 32'hffff_ffff);
        wait_irq(1'b0, 10);
    endtask

    // ------------------------------------------------------------
    // Sequence

    initial begin
        errors   = 0;
        rng      = 32'd17;
        rst_n    = 1'b0;
        dbg_halt = 1'b0;
        bus_req  = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        test_reset();
        test_pad_groups();
        test_gpio_pulls();
        test_slot_decode();
        test_timer_count();
        test_timer_irq();
        $display("Checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
